/* quan_cbr_shell.f */
logic/qconv_pkg.sv
logic/quan_cbr_shell_ctrl.sv
logic/sa_mac_array.sv
logic/quant_coef_regs.sv
logic/quant_postproc.sv
logic/conv_out_fifo.sv
logic/quan_cbr_shell.sv
testbench/quan_cbr_shell_tb.sv

/* Makefile */
TOP = quan_cbr_shell_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f quan_cbr_shell.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f quan_cbr_shell.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

/* testbench/quan_cbr_shell_tb.sv */
module quan_cbr_shell_tb
  import qconv_pkg::*;
();

  localparam int CLK_PERIOD  = 40;
  localparam int NUM_ENTRIES = 7;
  localparam int MAX_PIX     = 64;
  localparam int MARGIN      = 4;

  localparam logic [1:0] STYLE_RANDOM = 2'd0;
  localparam logic [1:0] STYLE_POS    = 2'd1;  // Large positive bias, shift 0
  localparam logic [1:0] STYLE_NEG    = 2'd2;  // Large negative bias

  typedef struct packed {
    logic [3:0]  mode;
    logic [15:0] pix;
    logic [1:0]  style;
    logic        b2b;    // Tiles follow each other without reset
    logic [3:0]  tiles;
  } tile_cfg_t;

  // Mode, pixel count, coefficient style, back-to-back, tile count
  localparam tile_cfg_t TILE_TABLE [NUM_ENTRIES] = '{
    '{4'd0, 16'd4,  STYLE_RANDOM, 1'b0, 4'd1},
    '{4'd1, 16'd7,  STYLE_RANDOM, 1'b0, 4'd2},
    '{4'd0, 16'd12, STYLE_RANDOM, 1'b1, 4'd3},
    '{4'd1, 16'd0,  STYLE_RANDOM, 1'b1, 4'd2},
    '{4'd0, 16'd5,  STYLE_NEG,    1'b0, 4'd1},
    '{4'd1, 16'd9,  STYLE_POS,    1'b1, 4'd2},
    '{4'd0, 16'd20, STYLE_POS,    1'b0, 4'd1}
  };

  logic                     clk = 1'b0;
  logic                     reset;
  logic                     re_fm_en;
  logic signed [FM_W-1:0]   fm_data;
  logic [WT_ROW_W-1:0]      wt_row;
  logic [MODE_W-1:0]        mode_init;
  logic [PIX_CNT_W-1:0]     pixel_count_init;
  logic                     coef_wr_en;
  logic [ROW_IDX_W-1:0]     coef_wr_addr;
  logic [E_W-1:0]           coef_wr_e;
  logic signed [BIAS_W-1:0] coef_wr_bias;
  logic [SHIFT_W-1:0]       coef_wr_shift;
  logic                     rd_en;
  logic [OUT_W-1:0]         rd_data;
  logic                     empty;
  logic                     full;
  logic                     tile_done;

  int seed = 32'h499a398f;
  int cycle_cnt = 0;
  int tile_start;

  // Reference copies of the coefficients and the current tile
  logic [E_W-1:0]         coef_e     [SA_ROWS];
  longint                 coef_bias  [SA_ROWS];
  int                     coef_shift [SA_ROWS];
  logic signed [FM_W-1:0] fm_buf     [MAX_PIX];
  logic [WT_ROW_W-1:0]    wt_buf     [MAX_PIX];
  logic [OUT_W-1:0]       expected_q [$];

  quan_cbr_shell i_quan_cbr_shell (
    .clk, .reset, .re_fm_en, .fm_data, .wt_row, .mode_init, .pixel_count_init,
    .coef_wr_en, .coef_wr_addr, .coef_wr_e, .coef_wr_bias, .coef_wr_shift,
    .rd_en, .rd_data, .empty, .full, .tile_done
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  ////////////////////
  // Helpers

  task automatic check_value(input string what, input longint actual, input longint expected);
    if (actual != expected) begin
      $display("Fail at time %0t: %s, got %0d, expected %0d", $time, what, actual, expected);
      $display("Verification failed");
      $fatal(1);
    end
  endtask

  // Config is sampled by the DUT while reset is high
  task automatic apply_reset(input logic [3:0] mode, input logic [15:0] pix);
    reset            = 1'b1;
    mode_init        = mode;
    pixel_count_init = pix;
    re_fm_en         = 1'b0;
    rd_en            = 1'b0;
    coef_wr_en       = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic write_coefs(input logic [1:0] style, input logic [3:0] mode);
    for (int r = 0; r < SA_ROWS; r++) begin
      coef_e[r] = E_W'($random(seed) & 255);
      case (style)
        STYLE_POS: begin
          coef_bias[r]  = 64'sh4000_0000;
          coef_shift[r] = 0;
        end
        STYLE_NEG: begin
          coef_bias[r]  = -64'sh4000_0000;
          coef_shift[r] = $random(seed) & 31;
        end
        default: begin
          coef_bias[r]  = $random(seed) % 50000;
          coef_shift[r] = (mode == MODE_SCALE) ? 12 : 2;
          coef_shift[r] = coef_shift[r] + ($random(seed) & 7);
        end
      endcase
      @(negedge clk);
      // Nothing may reach the FIFO before a tile starts
      check_value("empty while idle", longint'(empty), 1);
      check_value("tile_done while idle", longint'(tile_done), 0);
      coef_wr_en    = 1'b1;
      coef_wr_addr  = ROW_IDX_W'(r);
      coef_wr_e     = coef_e[r];
      coef_wr_bias  = BIAS_W'(coef_bias[r]);
      coef_wr_shift = SHIFT_W'(coef_shift[r]);
    end
    @(negedge clk);
    coef_wr_en = 1'b0;
  endtask

  // Random tile data plus the expected byte of every row
  task automatic make_tile(input int n, input logic [3:0] mode);
    longint acc;
    longint sum;
    for (int i = 0; i <= n; i++) begin
      fm_buf[i] = FM_W'($random(seed));
      wt_buf[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
    end
    for (int r = 0; r < SA_ROWS; r++) begin
      acc = 0;
      for (int i = 0; i <= n; i++) begin
        acc += longint'(fm_buf[i]) * longint'($signed(wt_buf[i][r*WT_W +: WT_W]));
      end
      if (mode == MODE_SCALE) begin
        acc = acc * longint'(coef_e[r]);
      end
      sum = acc + coef_bias[r];
      if (sum < 0) begin
        sum = 0;  // ReLU
      end else begin
        sum = sum >>> coef_shift[r];
      end
      if (sum > 255) begin
        sum = 255;
      end
      expected_q.push_back(OUT_W'(sum));
    end
  endtask

  task automatic stream_tile(input int n);
    for (int i = 0; i <= n; i++) begin
      @(negedge clk);
      if (i == 0) begin
        tile_start = cycle_cnt;
      end
      re_fm_en = (i == 0);
      fm_data  = fm_buf[i];
      wt_row   = wt_buf[i];
    end
    @(negedge clk);
    re_fm_en = 1'b0;
    fm_data  = '0;
    wt_row   = '0;
  endtask

  task automatic wait_tile_done(input int n);
    while (!tile_done) @(negedge clk);
    check_value("tile_done cycle", longint'(cycle_cnt - tile_start), longint'(n + 34));
  endtask

  // Reads n bytes, data shows up one cycle after rd_en
  task automatic read_bytes(input int n);
    logic [OUT_W-1:0] exp_byte;
    for (int k = 0; k <= n; k++) begin
      @(negedge clk);
      if (k == 0) begin
        check_value("full with one tile buffered", longint'(full), 0);
      end else begin
        exp_byte = expected_q.pop_front();
        check_value($sformatf("FIFO byte of row %0d", k - 1), longint'(rd_data),
                    longint'(exp_byte));
      end
      if (k < n) begin
        check_value("FIFO holds the tile", longint'(empty), 0);
      end
      rd_en = (k < n);
    end
    check_value("empty after the tile was read", longint'(empty), 1);
  endtask

  ////////////////////
  // Main sequence

  initial begin
    tile_cfg_t cfg;
    reset            = 1'b1;
    re_fm_en         = 1'b0;
    fm_data          = '0;
    wt_row           = '0;
    mode_init        = '0;
    pixel_count_init = '0;
    coef_wr_en       = 1'b0;
    coef_wr_addr     = '0;
    coef_wr_e        = '0;
    coef_wr_bias     = '0;
    coef_wr_shift    = '0;
    rd_en            = 1'b0;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      cfg = TILE_TABLE[e];
      apply_reset(cfg.mode, cfg.pix);
      write_coefs(cfg.style, cfg.mode);
      for (int t = 0; t < int'(cfg.tiles); t++) begin
        if (t > 0 && !cfg.b2b) begin
          apply_reset(cfg.mode, cfg.pix);
        end
        make_tile(int'(cfg.pix), cfg.mode);
        if (t > 0 && cfg.b2b) begin
          // Previous tile drains while the next one streams
          fork
            stream_tile(int'(cfg.pix));
            read_bytes(SA_ROWS);
          join
        end else begin
          stream_tile(int'(cfg.pix));
        end
        wait_tile_done(int'(cfg.pix));
        if (!cfg.b2b || t == int'(cfg.tiles) - 1) begin
          read_bytes(SA_ROWS);
        end
      end
    end
    $display("Verification passed");
    $finish;
  end

  ////////////////////
  // Watchdog

  initial begin
    longint limit;
    limit = 0;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      limit += (longint'(TILE_TABLE[e].pix) + 40) * longint'(TILE_TABLE[e].tiles);
    end
    limit = limit * CLK_PERIOD * MARGIN;
    #(limit);
    $display("Timeout: the tiles did not finish within %0d time units", limit);
    $display("Verification failed");
    $fatal(1);
  end

endmodule

/* logic/quan_cbr_shell.sv */
module quan_cbr_shell
  import qconv_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     re_fm_en,
  input  logic signed [FM_W-1:0]   fm_data,
  input  logic [WT_ROW_W-1:0]      wt_row,
  input  logic [MODE_W-1:0]        mode_init,
  input  logic [PIX_CNT_W-1:0]     pixel_count_init,
  input  logic                     coef_wr_en,
  input  logic [ROW_IDX_W-1:0]     coef_wr_addr,
  input  logic [E_W-1:0]           coef_wr_e,
  input  logic signed [BIAS_W-1:0] coef_wr_bias,
  input  logic [SHIFT_W-1:0]       coef_wr_shift,
  input  logic                     rd_en,
  output logic [OUT_W-1:0]         rd_data,
  output logic                     empty,
  output logic                     full,
  output logic                     tile_done
);

  logic                     pixel_valid;
  logic                     sa_en;
  logic                     sa_reset;
  logic [ROW_IDX_W-1:0]     row_idx;
  logic                     row_valid;
  logic                     mult_e_sel;
  logic                     fifo_wr_en;
  logic signed [ACC_W-1:0]  acc_row;
  logic [E_W-1:0]           scale_e;
  logic signed [BIAS_W-1:0] bias;
  logic [SHIFT_W-1:0]       shift;
  logic [OUT_W-1:0]         q_out;

  quan_cbr_shell_ctrl i_ctrl (
    .clk, .reset, .re_fm_en, .mode_init, .pixel_count_init,
    .pixel_valid, .sa_en, .sa_reset, .row_idx, .row_valid,
    .mult_e_sel, .fifo_wr_en, .tile_done
  );

  sa_mac_array i_sa_mac_array (
    .clk, .reset, .pixel_valid, .sa_en, .sa_reset,
    .fm_data, .wt_row, .row_idx, .acc_row
  );

  // Coefficient reads follow the drain row index
  quant_coef_regs i_coef_regs (
    .clk, .reset, .coef_wr_en, .coef_wr_addr, .coef_wr_e, .coef_wr_bias,
    .coef_wr_shift, .row_idx, .row_valid, .scale_e, .bias, .shift
  );

  quant_postproc i_postproc (
    .clk, .reset, .acc_row, .mult_e_sel, .scale_e, .bias, .shift, .q_out
  );

  conv_out_fifo i_out_fifo (
    .clk, .reset, .wr_en(fifo_wr_en), .wr_data(q_out),
    .rd_en, .rd_data, .empty, .full
  );

endmodule

/* logic/conv_out_fifo.sv */
module conv_out_fifo
  import qconv_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             wr_en,
  input  logic [OUT_W-1:0] wr_data,
  input  logic             rd_en,
  output logic [OUT_W-1:0] rd_data,
  output logic             empty,
  output logic             full
);

  logic [OUT_W-1:0]   mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               wr_ok;
  logic               rd_ok;

  assign wr_ok = wr_en && !full;   // Overflow drops the byte
  assign rd_ok = rd_en && !empty;
  assign empty = (count == '0);
  assign full  = (count == FIFO_DEPTH);

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
    if (rd_ok) begin
      rd_data <= mem[rd_ptr];  // Valid the cycle after rd_en
    end
  end

  // Pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      count <= count + wr_ok - rd_ok;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    wr_en |-> !full);

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    rd_en |-> !empty);

endmodule

/* logic/quant_postproc.sv */
module quant_postproc
  import qconv_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic signed [ACC_W-1:0]  acc_row,
  input  logic                     mult_e_sel,
  input  logic [E_W-1:0]           scale_e,
  input  logic signed [BIAS_W-1:0] bias,
  input  logic [SHIFT_W-1:0]       shift,
  output logic [OUT_W-1:0]         q_out
);

  logic signed [PROD_W-1:0] acc_ext;
  logic signed [PROD_W-1:0] prod;
  logic signed [PROD_W-1:0] scaled_q;
  logic signed [SUM_W-1:0]  biased_q;
  logic signed [SUM_W-1:0]  shifted;

  ////////////////////
  // Stage 1 scale

  assign acc_ext = {{(PROD_W - ACC_W){acc_row[ACC_W-1]}}, acc_row};

  // Scale is unsigned, so a zero sign bit is prepended
  assign prod = acc_row * $signed({1'b0, scale_e});

  always_ff @(posedge clk) begin
    if (reset) begin
      scaled_q <= '0;
    end else begin
      scaled_q <= mult_e_sel ? prod : acc_ext;  // Mode 0 passes the sum
    end
  end

  ////////////////////
  // Stage 2 bias

  always_ff @(posedge clk) begin
    if (reset) begin
      biased_q <= '0;
    end else begin
      biased_q <= scaled_q + bias;  // Both sign extended to SUM_W
    end
  end

  ////////////////////
  // Stage 3 relu, shift, clamp

  assign shifted = biased_q >>> shift;

  always_ff @(posedge clk) begin
    if (reset) begin
      q_out <= '0;
    end else if (biased_q[SUM_W-1]) begin
      q_out <= '0;  // ReLU
    end else if (shifted > OUT_MAX) begin
      q_out <= OUT_W'(OUT_MAX);
    end else begin
      q_out <= shifted[OUT_W-1:0];
    end
  end

endmodule

/* logic/quant_coef_regs.sv */
module quant_coef_regs
  import qconv_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     coef_wr_en,
  input  logic [ROW_IDX_W-1:0]     coef_wr_addr,
  input  logic [E_W-1:0]           coef_wr_e,
  input  logic signed [BIAS_W-1:0] coef_wr_bias,
  input  logic [SHIFT_W-1:0]       coef_wr_shift,
  input  logic [ROW_IDX_W-1:0]     row_idx,
  input  logic                     row_valid,
  output logic [E_W-1:0]           scale_e,
  output logic signed [BIAS_W-1:0] bias,
  output logic [SHIFT_W-1:0]       shift
);

  logic [E_W-1:0]           e_mem     [SA_ROWS];
  logic signed [BIAS_W-1:0] bias_mem  [SA_ROWS];
  logic [SHIFT_W-1:0]       shift_mem [SA_ROWS];
  logic [SHIFT_W-1:0]       shift_q;

  always_ff @(posedge clk) begin
    if (coef_wr_en) begin
      e_mem[coef_wr_addr]     <= coef_wr_e;
      bias_mem[coef_wr_addr]  <= coef_wr_bias;
      shift_mem[coef_wr_addr] <= coef_wr_shift;
    end
  end

  assign scale_e = e_mem[row_idx];  // Stage 1 uses it directly

  // Bias lines up with stage 2, shift with stage 3
  always_ff @(posedge clk) begin
    if (reset) begin
      bias    <= '0;
      shift_q <= '0;
      shift   <= '0;
    end else begin
      bias    <= bias_mem[row_idx];
      shift_q <= shift_mem[row_idx];
      shift   <= shift_q;
    end
  end

  // Coefficients stay fixed while the controller drains the rows
  a_no_write_in_window: assert property (@(posedge clk) disable iff (reset)
    row_valid |-> !coef_wr_en);

endmodule

/* logic/sa_mac_array.sv */
module sa_mac_array
  import qconv_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    pixel_valid,
  input  logic                    sa_en,
  input  logic                    sa_reset,
  input  logic signed [FM_W-1:0]  fm_data,
  input  logic [WT_ROW_W-1:0]     wt_row,
  input  logic [ROW_IDX_W-1:0]    row_idx,
  output logic signed [ACC_W-1:0] acc_row
);

  logic                    valid_q;
  logic signed [FM_W-1:0]  fm_q;
  logic [WT_ROW_W-1:0]     wt_q;
  logic signed [ACC_W-1:0] acc [SA_ROWS];

  ////////////////////
  // Input registers

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pixel_valid;
    end
  end

  always_ff @(posedge clk) begin
    fm_q <= fm_data;
    wt_q <= wt_row;
  end

  ////////////////////
  // Accumulate rows

  // Row r takes weight slice r of the weight word
  always_ff @(posedge clk) begin
    if (reset || sa_reset) begin
      for (int r = 0; r < SA_ROWS; r++) begin
        acc[r] <= '0;
      end
    end else if (valid_q && sa_en) begin
      for (int r = 0; r < SA_ROWS; r++) begin
        acc[r] <= acc[r] + fm_q * $signed(wt_q[r*WT_W +: WT_W]);
      end
    end
  end

  assign acc_row = acc[row_idx];  // Drain read port

endmodule

/* logic/quan_cbr_shell_ctrl.sv */
module quan_cbr_shell_ctrl
  import qconv_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 re_fm_en,
  input  logic [MODE_W-1:0]    mode_init,
  input  logic [PIX_CNT_W-1:0] pixel_count_init,
  output logic                 pixel_valid,
  output logic                 sa_en,
  output logic                 sa_reset,
  output logic [ROW_IDX_W-1:0] row_idx,
  output logic                 row_valid,
  output logic                 mult_e_sel,
  output logic                 fifo_wr_en,
  output logic                 tile_done
);

  logic [MODE_W-1:0]    mode;
  logic [PIX_CNT_W-1:0] pixel_count;
  logic                 pix_run;
  logic [PIX_CNT_W-1:0] pix_cnt;
  logic                 pix_active;
  logic                 pix_last;
  logic                 drain_run;
  logic [SA_CNT_W-1:0]  drain_cnt;
  logic                 drain_active;
  logic                 drain_last;
  logic                 win_close;
  logic [2:0]           stage_en;   // Scale, bias, relu stage enables
  logic [2:0]           stage_end;  // Window close following the stages
  logic                 tile_busy;

  // Configuration is sampled only while reset is held
  always_ff @(posedge clk) begin
    if (reset) begin
      mode        <= mode_init;
      pixel_count <= pixel_count_init;
    end
  end

  ////////////////////
  // Pixel stream

  assign pix_active  = re_fm_en || pix_run;
  assign pix_last    = pix_active && (pix_cnt == pixel_count);
  assign pixel_valid = pix_active;

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_run <= 1'b0;
      pix_cnt <= '0;
    end else if (pix_last) begin
      pix_run <= 1'b0;
      pix_cnt <= '0;
    end else if (pix_active) begin
      pix_run <= 1'b1;
      pix_cnt <= pix_cnt + 1'b1;
    end
  end

  ////////////////////
  // Drain phase

  assign drain_active = pix_last || drain_run;  // Value 0 sits on the last pixel
  assign drain_last   = drain_active && (drain_cnt == SA_CNT_END);
  assign win_close    = drain_active && (drain_cnt == DRAIN_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      drain_run <= 1'b0;
      drain_cnt <= '0;
    end else if (drain_last) begin
      drain_run <= 1'b0;
      drain_cnt <= '0;
    end else if (drain_active) begin
      drain_run <= 1'b1;
      drain_cnt <= drain_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      row_valid <= 1'b0;
    end else if (drain_active && (drain_cnt == DRAIN_FIRST - SA_CNT_W'(1))) begin
      row_valid <= 1'b1;
    end else if (win_close) begin
      row_valid <= 1'b0;
    end
  end

  // Window starts at 16, so the low bits count rows 0 to 15
  assign row_idx    = row_valid ? drain_cnt[ROW_IDX_W-1:0] : '0;
  assign mult_e_sel = row_valid && (mode == MODE_SCALE);

  // Accumulate from the cycle after start, clear once the rows are read
  always_ff @(posedge clk) begin
    if (reset) begin
      sa_en    <= 1'b0;
      sa_reset <= 1'b0;
    end else if (re_fm_en) begin
      sa_en    <= 1'b1;
      sa_reset <= 1'b0;
    end else if (win_close) begin
      sa_en    <= 1'b0;
      sa_reset <= 1'b1;
    end else begin
      sa_reset <= 1'b0;
    end
  end

  ////////////////////
  // Output pipeline enables

  always_ff @(posedge clk) begin
    if (reset) begin
      stage_en  <= '0;
      stage_end <= '0;
    end else begin
      stage_en  <= {stage_en[1:0], row_valid};
      stage_end <= {stage_end[1:0], win_close};
    end
  end

  assign fifo_wr_en = stage_en[2];
  assign tile_done  = stage_end[2];  // Same cycle as the last FIFO write

  always_ff @(posedge clk) begin
    if (reset) begin
      tile_busy <= 1'b0;
    end else if (re_fm_en) begin
      tile_busy <= 1'b1;
    end else if (tile_done) begin
      tile_busy <= 1'b0;
    end
  end

  // Next tile only after the final byte reached the FIFO
  a_no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
    re_fm_en |-> !tile_busy);

  a_sa_reset_single: assert property (@(posedge clk) disable iff (reset)
    sa_reset |=> !sa_reset);

endmodule

/* logic/qconv_pkg.sv */
package qconv_pkg;

  ////////////////////
  // Array geometry

  localparam int SA_ROWS   = 16;  // One output channel per row
  localparam int ROW_IDX_W = 4;

  localparam int FM_W     = 8;  // Signed feature word
  localparam int WT_W     = 8;  // Signed weight
  localparam int WT_ROW_W = SA_ROWS * WT_W;
  localparam int ACC_W    = 32;

  ////////////////////
  // Quantization datapath

  localparam int E_W     = 16;  // Unsigned per-channel scale
  localparam int PROD_W  = 48;
  localparam int SUM_W   = PROD_W + 1;  // One guard bit for the bias add
  localparam int BIAS_W  = 32;
  localparam int SHIFT_W = 5;
  localparam int OUT_W   = 8;
  localparam int OUT_MAX = (1 << OUT_W) - 1;

  ////////////////////
  // Controller phases

  localparam int MODE_W    = 4;
  localparam int PIX_CNT_W = 16;
  localparam int SA_CNT_W  = 6;

  localparam logic [SA_CNT_W-1:0] DRAIN_FIRST = 6'd16;  // Row window opens
  localparam logic [SA_CNT_W-1:0] DRAIN_LAST  = 6'd31;  // Row window closes
  localparam logic [SA_CNT_W-1:0] SA_CNT_END  = 6'd32;

  localparam logic [MODE_W-1:0] MODE_SCALE = 4'd1;

  // Output buffer
  localparam int FIFO_DEPTH = 32;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

endpackage
